// ==== common/prefetch_settings.svh ====
// prefetch buffer settings
// bus widths and FIFO depth shared by the fetch RTL

`ifndef PREFETCH_SETTINGS_SVH
`define PREFETCH_SETTINGS_SVH

// byte address width
`define PF_ADDR_W 32

// instruction memory word width
`define PF_DATA_W 32

// word entries in the fetch FIFO
// three or more, the FSM stops requesting one entry early
`define PF_FIFO_DEPTH 4

`endif

// ==== common/prefetch_pkg.sv ====
// prefetch data types
// address, memory word and halfword vectors used across the fetch path

`include "prefetch_settings.svh"

package prefetch_pkg;

  // byte address
  // bit 1 selects the upper halfword of a word
  typedef logic [`PF_ADDR_W-1:0] addr_t;

  // one instruction memory word
  typedef logic [`PF_DATA_W-1:0] word_t;

  // one 16-bit halfword
  // a compressed instruction or half of a 32-bit one
  typedef logic [15:0] half_t;

endpackage

// ==== common/fetch_ctrl_pkg.sv ====
// fetch control types
// state encoding of the memory request FSM

package fetch_ctrl_pkg;

  // request FSM states
  typedef enum logic [1:0] {
    // nothing outstanding
    FETCH_IDLE,
    // request raised, no grant yet
    FETCH_WAIT_GNT,
    // granted, data not back yet
    FETCH_WAIT_RVALID,
    // a branch killed the request in flight
    FETCH_WAIT_ABORTED
  } fetch_state_e;

endpackage

// ==== prefetch/fetch_fsm.sv ====
// fetch request FSM
// drives the req/gnt/rvalid memory protocol, one request outstanding, branch abort

`timescale 1ns/10ps

module fetch_fsm import fetch_ctrl_pkg::*; import prefetch_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req_i,
  input  logic  branch_i,
  input  addr_t addr_i,
  input  logic  fifo_ready_i,
  input  addr_t next_fetch_addr_i,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  output logic  addr_load_o,
  output logic  fifo_push_o,
  output logic  fifo_flush_o,
  output logic  busy_o
);

  fetch_state_e state_q;
  fetch_state_e state_d;
  // word of the request already placed, counter runs one word ahead
  addr_t        cur_word_addr;

  assign cur_word_addr = next_fetch_addr_i - addr_t'(4);

  // a branch always throws away whatever is buffered
  assign fifo_flush_o = branch_i;
  assign busy_o       = (state_q != FETCH_IDLE) || instr_req_o;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d      = state_q;
    instr_req_o  = 1'b0;
    instr_addr_o = branch_i ? addr_i : next_fetch_addr_i;
    addr_load_o  = 1'b0;
    fifo_push_o  = 1'b0;

    case (state_q)
      FETCH_IDLE: begin
        // a branch may fetch even with a full fifo, the flush frees it
        if (req_i && (fifo_ready_i || branch_i)) begin
          instr_req_o = 1'b1;
          addr_load_o = 1'b1;
          state_d     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
        end
      end

      FETCH_WAIT_GNT: begin
        // keep asking, a branch just swaps the address
        instr_req_o = 1'b1;
        if (branch_i) begin
          addr_load_o = 1'b1;
        end else begin
          instr_addr_o = cur_word_addr;
        end
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT_RVALID;
        end
      end

      FETCH_WAIT_RVALID: begin
        if (req_i && (fifo_ready_i || branch_i)) begin
          if (instr_rvalid_i) begin
            // data back, next request goes out in the same cycle
            instr_req_o = 1'b1;
            fifo_push_o = 1'b1;
            addr_load_o = 1'b1;
            state_d     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
          end else if (branch_i) begin
            // remember the target, old data still has to drain
            addr_load_o = 1'b1;
            state_d     = FETCH_WAIT_ABORTED;
          end
        end else if (instr_rvalid_i) begin
          fifo_push_o = 1'b1;
          state_d     = FETCH_IDLE;
        end
      end

      FETCH_WAIT_ABORTED: begin
        if (branch_i) begin
          addr_load_o = 1'b1;
        end else begin
          instr_addr_o = cur_word_addr;
        end
        // stale rvalid, drop the data and fetch the target right away
        if (instr_rvalid_i) begin
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
        end
      end

      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FETCH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // an ungranted request stays up on the same word until a branch moves it
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=>
      instr_req_o && (branch_i || ((instr_addr_o >> 2) == $past(instr_addr_o >> 2))))
    else $error("request dropped or moved before grant");

endmodule

// ==== prefetch/fetch_addr_cnt.sv ====
// fetch address counter
// holds the last requested address and offers the next sequential word

`timescale 1ns/10ps

`include "prefetch_settings.svh"

module fetch_addr_cnt import prefetch_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // load strobe from the fsm
  input  logic  addr_load_i,
  // branch target or sequential address
  input  addr_t load_addr_i,
  // address of the request in flight
  output addr_t fetch_addr_o,
  // word after it
  output addr_t next_fetch_addr_o
);

  addr_t fetch_addr_q;
  addr_t word_addr;

  ////////////////////
  // address register
  ////////////////////

  // keeps bit 1 of a branch target
  // so the fifo entry knows to start at the upper halfword
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_addr_q <= '0;
    end else if (addr_load_i) begin
      fetch_addr_q <= load_addr_i;
    end
  end

  assign fetch_addr_o = fetch_addr_q;

  // drop the halfword offset before stepping
  assign word_addr = {fetch_addr_q[`PF_ADDR_W-1:2], 2'b00};

  // sequential fetch is always a whole word on
  assign next_fetch_addr_o = word_addr + addr_t'(4);

endmodule

// ==== prefetch/fetch_fifo.sv ====
// fetch word FIFO
// per-entry addresses, bypass of the arriving word, flush and head address update

`timescale 1ns/10ps

`include "prefetch_settings.svh"

module fetch_fifo import prefetch_pkg::*; #(
  parameter int DEPTH = `PF_FIFO_DEPTH
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  flush_i,
  // write side
  input  logic  push_i,
  input  addr_t push_addr_i,
  input  word_t push_rdata_i,
  output logic  ready_o,
  // two oldest words, bypass applied
  output logic  head_valid_o,
  output word_t head_rdata_o,
  output addr_t head_addr_o,
  output logic  next_valid_o,
  output word_t next_rdata_o,
  // consume control from the aligner
  input  logic  pop_i,
  input  logic  advance_i,
  input  addr_t adv_addr_i
);

  // entry 0 is the head
  addr_t            addr_q    [DEPTH];
  word_t            rdata_q   [DEPTH];
  logic [DEPTH-1:0] valid_q;
  addr_t            addr_ins  [DEPTH];
  word_t            rdata_ins [DEPTH];
  logic [DEPTH-1:0] valid_ins;
  addr_t            addr_d    [DEPTH];
  word_t            rdata_d   [DEPTH];
  logic [DEPTH-1:0] valid_d;
  logic             slot_found;

  ////////////////////
  // read side
  ////////////////////

  // empty slots show the word arriving right now
  assign head_valid_o = valid_q[0] || push_i;
  assign head_rdata_o = valid_q[0] ? rdata_q[0] : push_rdata_i;
  assign head_addr_o  = valid_q[0] ? addr_q[0] : push_addr_i;
  assign next_valid_o = valid_q[1] || (valid_q[0] && push_i);
  assign next_rdata_o = valid_q[1] ? rdata_q[1] : push_rdata_i;

  // one slot of slack for the word still in flight
  assign ready_o = !valid_q[DEPTH-2];

  // write into the first free slot
  always_comb begin
    addr_ins   = addr_q;
    rdata_ins  = rdata_q;
    valid_ins  = valid_q;
    slot_found = 1'b0;
    if (push_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        if (!valid_q[i] && !slot_found) begin
          addr_ins[i]  = push_addr_i;
          rdata_ins[i] = push_rdata_i;
          valid_ins[i] = 1'b1;
          slot_found   = 1'b1;
        end
      end
    end
  end

  // consume, shift on pop, head address always from the aligner
  always_comb begin
    addr_d  = addr_ins;
    rdata_d = rdata_ins;
    valid_d = valid_ins;
    if (advance_i) begin
      if (pop_i) begin
        for (int i = 0; i < DEPTH-1; i++) begin
          addr_d[i]  = addr_ins[i+1];
          rdata_d[i] = rdata_ins[i+1];
          valid_d[i] = valid_ins[i+1];
        end
        valid_d[DEPTH-1] = 1'b0;
      end
      addr_d[0] = adv_addr_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    addr_q  <= addr_d;
    rdata_q <= rdata_d;
  end

  // fsm request gating has to keep the last slot free
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> (!valid_q[DEPTH-1] || flush_i))
    else $error("fetch fifo overflow");

endmodule

// ==== prefetch/instr_aligner.sv ====
// instruction aligner
// cuts 16-bit and 32-bit instructions out of the word stream, also across words

`timescale 1ns/10ps

`include "prefetch_settings.svh"

module instr_aligner import prefetch_pkg::*; (
  input  logic  head_valid_i,
  input  word_t head_rdata_i,
  input  addr_t head_addr_i,
  input  logic  next_valid_i,
  input  word_t next_rdata_i,
  // core side
  input  logic  ready_i,
  output logic  valid_o,
  output word_t rdata_o,
  output addr_t addr_o,
  // fifo update
  output logic  advance_o,
  output logic  pop_o,
  output addr_t adv_addr_o
);

  half_t head_hi;
  half_t next_lo;
  logic  unaligned;
  logic  aligned_compr;
  logic  unaligned_compr;
  addr_t word_next;

  assign head_hi   = head_rdata_i[31:16];
  assign next_lo   = next_rdata_i[15:0];
  assign unaligned = head_addr_i[1];

  // low two bits 11 mark a full 32-bit instruction
  assign aligned_compr   = head_rdata_i[1:0] != 2'b11;
  assign unaligned_compr = head_hi[1:0] != 2'b11;

  // unaligned word, upper half of head below lower half of next
  assign rdata_o = unaligned ? {next_lo, head_hi} : head_rdata_i;
  assign addr_o  = head_addr_i;

  // a full instruction on the upper half needs the next word too
  assign valid_o   = (unaligned && !unaligned_compr) ? (head_valid_i && next_valid_i)
                                                     : head_valid_i;
  assign advance_o = valid_o && ready_i;

  assign word_next = {head_addr_i[`PF_ADDR_W-1:2], 2'b00} + addr_t'(4);

  ////////////////////
  // next head address
  ////////////////////

  always_comb begin
    pop_o      = 1'b1;
    adv_addr_o = word_next;
    if (!unaligned && aligned_compr) begin
      // stay in this word, move to its upper half
      pop_o      = 1'b0;
      adv_addr_o = {head_addr_i[`PF_ADDR_W-1:2], 2'b10};
    end else if (unaligned && !unaligned_compr) begin
      // lower half of the next word is used up
      adv_addr_o = {word_next[`PF_ADDR_W-1:2], 2'b10};
    end
  end

endmodule

// ==== prefetch/prefetch_buffer.sv ====
// instruction prefetch buffer
// fetches words from instruction memory and hands aligned instructions to the core

`timescale 1ns/10ps

`include "prefetch_settings.svh"

module prefetch_buffer import prefetch_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // core side
  input  logic  req_i,
  input  logic  branch_i,
  input  addr_t addr_i,
  input  logic  ready_i,
  output logic  valid_o,
  output word_t rdata_o,
  output addr_t addr_o,
  // instruction memory side
  output logic  instr_req_o,
  input  logic  instr_gnt_i,
  output addr_t instr_addr_o,
  input  word_t instr_rdata_i,
  input  logic  instr_rvalid_i,
  // status
  output logic  busy_o
);

  // fsm to address counter
  logic  addr_load;
  addr_t sel_addr;
  addr_t fetch_addr;
  addr_t next_fetch_addr;

  // fsm to fifo
  logic  fifo_push;
  logic  fifo_flush;
  logic  fifo_ready;

  // fifo to aligner
  logic  head_valid;
  word_t head_rdata;
  addr_t head_addr;
  logic  next_valid;
  word_t next_rdata;

  // aligner back to fifo
  logic  pop_head;
  logic  head_advance;
  addr_t adv_addr;

  // memory sees word addresses only
  // the halfword bit stays in the counter for the fifo entry
  assign instr_addr_o = {sel_addr[`PF_ADDR_W-1:2], 2'b00};

  fetch_fsm fsm_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_i             (req_i),
    .branch_i          (branch_i),
    .addr_i            (addr_i),
    .fifo_ready_i      (fifo_ready),
    .next_fetch_addr_i (next_fetch_addr),
    .instr_gnt_i       (instr_gnt_i),
    .instr_rvalid_i    (instr_rvalid_i),
    .instr_req_o       (instr_req_o),
    .instr_addr_o      (sel_addr),
    .addr_load_o       (addr_load),
    .fifo_push_o       (fifo_push),
    .fifo_flush_o      (fifo_flush),
    .busy_o            (busy_o)
  );

  fetch_addr_cnt addr_cnt_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .addr_load_i       (addr_load),
    .load_addr_i       (sel_addr),
    .fetch_addr_o      (fetch_addr),
    .next_fetch_addr_o (next_fetch_addr)
  );

  fetch_fifo #(
    .DEPTH (`PF_FIFO_DEPTH)
  ) fifo_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (fifo_flush),
    .push_i       (fifo_push),
    .push_addr_i  (fetch_addr),
    .push_rdata_i (instr_rdata_i),
    .ready_o      (fifo_ready),
    .head_valid_o (head_valid),
    .head_rdata_o (head_rdata),
    .head_addr_o  (head_addr),
    .next_valid_o (next_valid),
    .next_rdata_o (next_rdata),
    .pop_i        (pop_head),
    .advance_i    (head_advance),
    .adv_addr_i   (adv_addr)
  );

  instr_aligner aligner_i (
    .head_valid_i (head_valid),
    .head_rdata_i (head_rdata),
    .head_addr_i  (head_addr),
    .next_valid_i (next_valid),
    .next_rdata_i (next_rdata),
    .ready_i      (ready_i),
    .valid_o      (valid_o),
    .rdata_o      (rdata_o),
    .addr_o       (addr_o),
    .advance_o    (head_advance),
    .pop_o        (pop_head),
    .adv_addr_o   (adv_addr)
  );

endmodule

// ==== dv/tb_checks.svh ====
// prefetch buffer testbench checks
// typed compare tasks and the error counters they feed

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// one counter per kind of result
int addr_errors     = 0;
int instr_errors    = 0;
int flag_errors     = 0;
int protocol_errors = 0;

// instruction address at the core port
task automatic compare_addr(input string name, input addr_t expected, input addr_t actual);
  if (actual !== expected) begin
    addr_errors++;
    $display("error %s addr_o expected %h actual %h", name, expected, actual);
  end
endtask

// compressed instructions only carry the low halfword
task automatic compare_instr(input string name, input word_t expected, input word_t actual);
  word_t mask;
  mask = (expected[1:0] != 2'b11) ? word_t'(32'h0000_ffff) : '1;
  if ((actual & mask) !== (expected & mask)) begin
    instr_errors++;
    $display("error %s rdata_o expected %h actual %h", name, expected & mask, actual & mask);
  end
endtask

// single status or handshake bit
task automatic compare_flag(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    flag_errors++;
    $display("error %s expected %b actual %b", name, expected, actual);
  end
endtask

`endif

// ==== dv/tb_prefetch_buffer.sv ====
// prefetch buffer testbench
// random memory responder and a program counter model of the instruction stream

`timescale 1ns/10ps

module tb_prefetch_buffer import prefetch_pkg::*; ();

  localparam int CLK_PERIOD     = 100;
  localparam int TEST_CYCLES    = 2000;
  // a quarter of slack on top of the test length
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

  logic  clk;
  logic  rst_n;
  logic  req_i;
  logic  branch_i;
  addr_t addr_i;
  logic  ready_i;
  logic  valid_o;
  word_t rdata_o;
  addr_t addr_o;
  logic  instr_req_o;
  logic  instr_gnt_i;
  addr_t instr_addr_o;
  word_t instr_rdata_i;
  logic  instr_rvalid_i;
  logic  busy_o;

  integer seed;
  // instruction image, wraps every 1 KiB
  word_t  mem [256];
  // memory responder state
  logic   outstanding;
  int     gnt_wait;
  int     rv_wait;
  addr_t  out_addr;
  // reference model
  addr_t  model_pc;
  int     consumed;
  string  test_name;

  `include "tb_checks.svh"

  prefetch_buffer dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .addr_i         (addr_i),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o),
    .addr_o         (addr_o),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .busy_o         (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the tests did not reach their end in time");
    $display("Simulation failed");
    $finish;
  end

  ////////////////////
  // image and model
  ////////////////////

  // lower 512 bytes hold only 32-bit instructions, the rest about half compressed
  task automatic fill_image();
    word_t w;
    for (int i = 0; i < 256; i++) begin
      w = $random(seed);
      if (i < 128 || ($random(seed) & 1)) begin
        w[1:0] = 2'b11;
      end else begin
        w[1:0] = 2'({$random(seed)} % 3);
      end
      if ($random(seed) & 1) begin
        w[17:16] = 2'b11;
      end else begin
        w[17:16] = 2'({$random(seed)} % 3);
      end
      mem[i] = w;
    end
  endtask

  function automatic half_t image_half(input addr_t a);
    word_t w;
    w = mem[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // consumed instruction must sit at the model pc
  task automatic check_consume();
    half_t lo;
    word_t expected;
    if (valid_o && ready_i) begin
      lo       = image_half(model_pc);
      expected = {image_half(model_pc + addr_t'(2)), lo};
      compare_addr(test_name, model_pc, addr_o);
      compare_instr(test_name, expected, rdata_o);
      model_pc = model_pc + ((lo[1:0] == 2'b11) ? addr_t'(4) : addr_t'(2));
      consumed++;
    end
    if (branch_i) begin
      model_pc = addr_i;
    end
  endtask

  ////////////////////
  // memory responder
  ////////////////////

  task automatic update_memory();
    if (instr_rvalid_i) begin
      outstanding = 1'b0;
    end else if (outstanding) begin
      rv_wait = rv_wait - 1;
    end
    // the returning word frees the slot in its own cycle
    if (instr_req_o && outstanding) begin
      protocol_errors++;
      $display("%s: request raised while another one was still outstanding", test_name);
    end
    if (instr_req_o && instr_gnt_i) begin
      if (instr_addr_o[1:0] != 2'b00) begin
        protocol_errors++;
        $display("%s: memory request address is not word aligned", test_name);
      end
      outstanding = 1'b1;
      out_addr    = instr_addr_o;
      rv_wait     = 1 + {$random(seed)} % 3;
      gnt_wait    = {$random(seed)} % 4;
    end else if (instr_req_o && gnt_wait > 0) begin
      gnt_wait = gnt_wait - 1;
    end
  endtask

  // inputs change on the falling edge, results are taken at the rising edge
  task automatic drive_cycle(input logic req, input logic ready, input logic branch,
                             input addr_t target);
    @(negedge clk);
    req_i          = req;
    ready_i        = ready;
    branch_i       = branch;
    addr_i         = target;
    instr_gnt_i    = (gnt_wait == 0);
    instr_rvalid_i = outstanding && (rv_wait == 1);
    instr_rdata_i  = instr_rvalid_i ? mem[out_addr[9:2]] : word_t'($random(seed));
    @(posedge clk);
    check_consume();
    update_memory();
  endtask

  task automatic random_cycle(input logic req, input int ready_pct, input int branch_pct);
    logic  branch;
    logic  ready;
    addr_t target;
    branch = ({$random(seed)} % 100) < branch_pct;
    ready  = ({$random(seed)} % 100) < ready_pct;
    target = addr_t'({$random(seed)}) & addr_t'(32'h3fe);
    // branches only come while the core stalls
    drive_cycle(req, ready && !branch, branch, target);
  endtask

  initial begin
    int n;
    seed           = 78;
    rst_n          = 1'b0;
    req_i          = 1'b0;
    branch_i       = 1'b0;
    addr_i         = '0;
    ready_i        = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rdata_i  = '0;
    instr_rvalid_i = 1'b0;
    outstanding    = 1'b0;
    gnt_wait       = 0;
    rv_wait        = 0;
    out_addr       = '0;
    model_pc       = '0;
    consumed       = 0;
    fill_image();

    // quiet outputs in reset and with req_i low
    test_name = "reset_idle";
    for (int i = 0; i < 15; i++) begin
      if (i == 5) begin
        @(negedge clk);
        rst_n = 1'b1;
      end
      drive_cycle(1'b0, 1'b1, 1'b0, '0);
      compare_flag("reset_idle instr_req_o", 1'b0, instr_req_o);
      compare_flag("reset_idle valid_o", 1'b0, valid_o);
      compare_flag("reset_idle busy_o", 1'b0, busy_o);
    end

    // aligned 32-bit stream from a word target
    test_name = "aligned_stream";
    drive_cycle(1'b1, 1'b0, 1'b1, addr_t'(32'h40));
    repeat (150) drive_cycle(1'b1, 1'b1, 1'b0, '0);

    // mixed stream starting on an upper halfword
    test_name = "mixed_stream";
    drive_cycle(1'b1, 1'b0, 1'b1, addr_t'(32'h206));
    repeat (200) drive_cycle(1'b1, 1'b1, 1'b0, '0);

    // random branches under random back-pressure
    test_name = "random_branch";
    repeat (1500) random_cycle(1'b1, 70, 3);

    // drop req_i, the last word drains and fetching stops
    test_name = "req_drop";
    n = 0;
    do begin
      random_cycle(1'b0, 60, 0);
      n++;
    end while (busy_o && n < 50);
    if (busy_o) begin
      protocol_errors++;
      $display("busy_o stayed high long after req_i dropped");
    end
    repeat (30) begin
      random_cycle(1'b0, 60, 0);
      compare_flag("req_drop instr_req_o", 1'b0, instr_req_o);
      compare_flag("req_drop busy_o", 1'b0, busy_o);
    end

    if (consumed < 100) begin
      protocol_errors++;
      $display("only %0d instructions reached the core", consumed);
    end

    $display("errors: addr %0d, instr %0d, flag %0d, protocol %0d (%0d instructions)",
             addr_errors, instr_errors, flag_errors, protocol_errors, consumed);
    if (addr_errors + instr_errors + flag_errors + protocol_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+common
+incdir+dv
common/prefetch_pkg.sv
common/fetch_ctrl_pkg.sv
prefetch/fetch_fsm.sv
prefetch/fetch_addr_cnt.sv
prefetch/fetch_fifo.sv
prefetch/instr_aligner.sv
prefetch/prefetch_buffer.sv
dv/tb_prefetch_buffer.sv

// ==== Bender.yml ====
package:
  name: prefetch_buffer

export_include_dirs:
  - common

sources:
  - files:
      - common/prefetch_pkg.sv
      - common/fetch_ctrl_pkg.sv
      - prefetch/fetch_fsm.sv
      - prefetch/fetch_addr_cnt.sv
      - prefetch/fetch_fifo.sv
      - prefetch/instr_aligner.sv
      - prefetch/prefetch_buffer.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_prefetch_buffer.sv
